/* files.f */
verilog/mcoi_motor_pkg.sv
verilog/mcoi_link_pkg.sv
verilog/link_interlock.sv
verilog/motor_channel.sv
verilog/status_readback.sv
verilog/mcoi_motor_io.sv
verification/mcoi_motor_io_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the motor path testbench with Verilator and run it.
# The exit status is the simulator's: zero on pass, non-zero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module mcoi_motor_io_tb \
   --Mdir obj_dir \
   -o mcoi_motor_io_tb \
   -f files.f
if [ $? -ne 0 ]; then
   echo "verilator build returned an error"
   exit 1
fi

./obj_dir/mcoi_motor_io_tb
status=$?
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit $status
fi

exit 0

/* verification/mcoi_motor_io_tb.sv */
// self-checking testbench of the motor path, random link, status and read traffic against a model
module mcoi_motor_io_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import mcoi_motor_pkg::*;
   import mcoi_link_pkg::*;

   localparam int NUM_MOTORS = 16;
   localparam int CLK_PERIOD = 8;
   localparam int RESET_CYCLES = 3;
   localparam int TEST_CYCLES = 3000;
   // drain cycles plus slack
   localparam int MARGIN_CYCLES = 100;
   localparam int WATCHDOG_NS = CLK_PERIOD * (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES);

   logic gbt_rx_clkrs;
   logic rst_i;
   link_word_t interlock_word;
   motor_frame_t rx_frame;
   logic [NUM_MOTORS-1:0] pfail_n;
   logic [NUM_MOTORS-1:0] sw_a_n;
   logic [NUM_MOTORS-1:0] sw_b_n;
   logic ar_valid;
   axi_addr_t ar_addr;
   logic r_ready;
   logic [NUM_MOTORS-1:0] motor_step;
   logic [NUM_MOTORS-1:0] motor_en;
   logic [NUM_MOTORS-1:0] motor_dir;
   logic [NUM_MOTORS-1:0] motor_boost;
   motor_frame_t tx_frame;
   logic ar_ready;
   logic r_valid;
   axi_data_t r_data;
   axi_resp_t r_resp;

   integer seed;
   // inputs as the DUT samples them at the coming edge
   logic appl_rst;
   link_word_t appl_word;
   motor_frame_t appl_frame;
   logic [NUM_MOTORS-1:0] appl_pfail;
   logic [NUM_MOTORS-1:0] appl_swa;
   logic [NUM_MOTORS-1:0] appl_swb;
   logic appl_arvalid;
   axi_addr_t appl_araddr;
   logic appl_rready;
   // model state, control register, status history and pending read
   motor_frame_t exp_ctrl;
   logic exp_locked;
   // 0..2 synchroniser stages, 3 the returned frame
   motor_frame_t stat_hist [0:3];
   logic rd_pending;
   logic rd_held;
   axi_data_t exp_rdata;
   axi_resp_t exp_rresp;
   int model_accepts;
   int dut_accepts;
   int dut_responses;
   int slverr_reads;
   int stalled_cycles;

   mcoi_motor_io #(
      .NUM_MOTORS (NUM_MOTORS)
   ) uut (
      .gbt_rx_clkrs (gbt_rx_clkrs),
      .rst_i (rst_i),
      .interlock_word_i (interlock_word),
      .rx_frame_i (rx_frame),
      .motor_pfail_n_i (pfail_n),
      .motor_sw_a_n_i (sw_a_n),
      .motor_sw_b_n_i (sw_b_n),
      .ar_valid_i (ar_valid),
      .ar_addr_i (ar_addr),
      .r_ready_i (r_ready),
      .motor_step_o (motor_step),
      .motor_en_o (motor_en),
      .motor_dir_o (motor_dir),
      .motor_boost_o (motor_boost),
      .tx_frame_o (tx_frame),
      .ar_ready_o (ar_ready),
      .r_valid_o (r_valid),
      .r_data_o (r_data),
      .r_resp_o (r_resp)
   );

   initial begin
      gbt_rx_clkrs = 1'b0;
      forever #(CLK_PERIOD / 2) gbt_rx_clkrs = ~gbt_rx_clkrs;
   end

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic compare_value(input string name, input logic [63:0] exp_v,
                                input logic [63:0] got_v);
      assert (got_v === exp_v) else begin
         $display("mismatch %s: expected 0x%0h, got 0x%0h", name, exp_v, got_v);
         abort_run();
      end
   endtask

   // register map: link status, word aligned motor slots, error word elsewhere
   function automatic void decode_read(input axi_addr_t addr, input logic locked,
                                       input motor_frame_t stat, output axi_data_t data,
                                       output axi_resp_t resp);
      int offs;
      offs = int'(addr) - int'(REG_MOTOR_BASE);
      data = BAD_ADDR_WORD;
      resp = RESP_SLVERR;
      if (addr == REG_LINK_STATUS) begin
         data = {31'd0, locked};
         resp = RESP_OKAY;
      end else if (offs >= 0 && offs < 4 * NUM_MOTORS && offs % 4 == 0) begin
         data = {28'd0, stat[offs +: 4]};
         resp = RESP_OKAY;
      end
   endfunction

   // ------------------------------------------------------------------------
   // model, advanced once per rising edge
   // ------------------------------------------------------------------------

   task automatic step_model();
      motor_frame_t raw;
      axi_data_t d;
      axi_resp_t r;
      rd_held = !appl_rst && rd_pending && !appl_rready;
      if (appl_rst) begin
         rd_pending = 1'b0;
         exp_locked = 1'b0;
         exp_ctrl = '1;
         for (int k = 0; k < 4; k++) begin
            stat_hist[k] = '0;
         end
      end else begin
         // read decode sees the status and lock flag from before this edge
         if (!rd_pending && appl_arvalid) begin
            decode_read(appl_araddr, exp_locked, stat_hist[2], d, r);
            exp_rdata = d;
            exp_rresp = r;
            rd_pending = 1'b1;
            model_accepts++;
            if (r == RESP_SLVERR) slverr_reads++;
         end else if (rd_pending && appl_rready) begin
            rd_pending = 1'b0;
         end
         if (rd_held) stalled_cycles++;
         // active-low lines inverted, overheat stays zero
         raw = '0;
         for (int m = 0; m < NUM_MOTORS; m++) begin
            raw[4 * m + STAT_FAIL_BIT] = ~appl_pfail[m];
            raw[4 * m + STAT_SWA_BIT] = ~appl_swa[m];
            raw[4 * m + STAT_SWB_BIT] = ~appl_swb[m];
         end
         for (int k = 3; k > 0; k--) begin
            stat_hist[k] = stat_hist[k-1];
         end
         stat_hist[0] = raw;
         exp_locked = (appl_word == INTERLOCK_KEY);
         exp_ctrl = exp_locked ? appl_frame : '1;
      end
   endtask

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------

   // quiesce stops new reads and takes every pending response
   task automatic drive_inputs(input logic quiesce);
      logic [31:0] rnd;
      logic [1:0] off;
      link_word_t word;
      motor_frame_t frame;
      axi_addr_t addr;
      rnd = $random(seed);
      word = (rnd % 32'd3 != 32'd0) ? INTERLOCK_KEY : $random(seed);
      frame = {$random(seed), $random(seed)};
      rnd = $random(seed);
      off = (rnd[13:12] == 2'b00) ? 2'b01 : rnd[13:12];
      // mix of mapped, misaligned and unmapped addresses
      case (rnd[2:0])
         3'd0: addr = REG_LINK_STATUS;
         3'd1, 3'd2, 3'd3: addr = REG_MOTOR_BASE + {2'b00, rnd[11:8], 2'b00};
         3'd4: addr = REG_MOTOR_BASE + {2'b00, rnd[11:8], 2'b00} + {6'd0, off};
         3'd5: addr = {1'b1, rnd[22:16]};
         3'd6: addr = {2'b00, rnd[21:16]};
         default: addr = rnd[31:24];
      endcase
      appl_word = word;
      appl_frame = frame;
      appl_araddr = addr;
      appl_arvalid = quiesce ? 1'b0 : rnd[4];
      appl_rready = quiesce ? 1'b1 : rnd[5];
      rnd = $random(seed);
      appl_pfail = rnd[NUM_MOTORS-1:0];
      rnd = $random(seed);
      appl_swa = rnd[NUM_MOTORS-1:0];
      rnd = $random(seed);
      appl_swb = rnd[NUM_MOTORS-1:0];
      interlock_word <= appl_word;
      rx_frame <= appl_frame;
      ar_addr <= appl_araddr;
      ar_valid <= appl_arvalid;
      r_ready <= appl_rready;
      pfail_n <= appl_pfail;
      sw_a_n <= appl_swa;
      sw_b_n <= appl_swb;
   endtask

   // ------------------------------------------------------------------------
   // checks, at the falling edge where every output is settled
   // ------------------------------------------------------------------------

   task automatic check_outputs();
      logic [NUM_MOTORS-1:0] e_step;
      logic [NUM_MOTORS-1:0] e_en;
      logic [NUM_MOTORS-1:0] e_dir;
      logic [NUM_MOTORS-1:0] e_boost;
      for (int m = 0; m < NUM_MOTORS; m++) begin
         e_step[m] = exp_ctrl[4 * m + CTRL_STEP_BIT];
         e_en[m] = exp_ctrl[4 * m + CTRL_DEACT_BIT];
         e_dir[m] = exp_ctrl[4 * m + CTRL_DIR_BIT];
         e_boost[m] = exp_ctrl[4 * m + CTRL_BOOST_BIT];
      end
      compare_value("motor_step_o", 64'(e_step), 64'(motor_step));
      compare_value("motor_en_o", 64'(e_en), 64'(motor_en));
      compare_value("motor_dir_o", 64'(e_dir), 64'(motor_dir));
      compare_value("motor_boost_o", 64'(e_boost), 64'(motor_boost));
      compare_value("tx_frame_o", stat_hist[3], tx_frame);
      compare_value("r_valid_o", 64'(rd_pending), 64'(r_valid));
      // one read outstanding, address channel closed meanwhile
      compare_value("ar_ready_o", 64'(!rd_pending), 64'(ar_ready));
      // expected word is fixed from acceptance on, so a stall must hold it
      if (rd_pending) begin
         compare_value("r_data_o", 64'(exp_rdata), 64'(r_data));
         compare_value("r_resp_o", 64'(exp_rresp), 64'(r_resp));
      end
   endtask

   task automatic run_cycle(input logic quiesce);
      @(posedge gbt_rx_clkrs);
      step_model();
      drive_inputs(quiesce);
      @(negedge gbt_rx_clkrs);
      check_outputs();
      // handshakes that complete at the coming edge
      if (!rst_i && ar_valid && ar_ready) dut_accepts++;
      if (!rst_i && r_valid && r_ready) dut_responses++;
   endtask

   // ------------------------------------------------------------------------
   // sequence
   // ------------------------------------------------------------------------

   initial begin
      seed = 32'h8f33;
      rst_i = 1'b1;
      interlock_word = '0;
      rx_frame = '0;
      pfail_n = '1;
      sw_a_n = '1;
      sw_b_n = '1;
      ar_valid = 1'b0;
      ar_addr = '0;
      r_ready = 1'b0;
      appl_rst = 1'b1;
      appl_word = '0;
      appl_frame = '0;
      appl_pfail = '1;
      appl_swa = '1;
      appl_swb = '1;
      appl_arvalid = 1'b0;
      appl_araddr = '0;
      appl_rready = 1'b0;
      rd_pending = 1'b0;
      exp_rdata = '0;
      exp_rresp = '0;
      model_accepts = 0;
      dut_accepts = 0;
      dut_responses = 0;
      slverr_reads = 0;
      stalled_cycles = 0;
      for (int c = 0; c < RESET_CYCLES; c++) begin
         @(posedge gbt_rx_clkrs);
         step_model();
         if (c == RESET_CYCLES - 1) begin
            rst_i <= 1'b0;
            appl_rst = 1'b0;
         end
         @(negedge gbt_rx_clkrs);
         check_outputs();
      end
      // drivers off, frame clear, read port idle
      compare_value("motor_en_o", 64'({NUM_MOTORS{1'b1}}), 64'(motor_en));
      compare_value("motor_step_o", 64'({NUM_MOTORS{1'b1}}), 64'(motor_step));
      compare_value("motor_dir_o", 64'({NUM_MOTORS{1'b1}}), 64'(motor_dir));
      compare_value("motor_boost_o", 64'({NUM_MOTORS{1'b1}}), 64'(motor_boost));
      compare_value("tx_frame_o", 64'd0, tx_frame);
      compare_value("r_valid_o", 64'd0, 64'(r_valid));
      compare_value("ar_ready_o", 64'd1, 64'(ar_ready));
      repeat (TEST_CYCLES) run_cycle(1'b0);
      // take the last response, then every accepted read must be answered once
      do run_cycle(1'b1); while (r_valid);
      compare_value("ar_ready_o handshakes", 64'(model_accepts), 64'(dut_accepts));
      compare_value("r_valid_o handshakes", 64'(dut_accepts), 64'(dut_responses));
      assert (slverr_reads > 0 && stalled_cycles > 0) else begin
         $display("random traffic produced no error read or no stalled response");
         abort_run();
      end
      $display("Simulation passed");
      $finish;
   end

   initial begin
      #WATCHDOG_NS;
      $display("watchdog expired before the test sequence finished");
      abort_run();
   end

endmodule

/* verilog/mcoi_motor_io.sv */
// top of the motor path: interlock, one channel per motor and the status readback
module mcoi_motor_io #(
   // 4 bits per motor in a 64-bit frame, so 1 to 16
   parameter int NUM_MOTORS = 16
) (
   input logic gbt_rx_clkrs,
   input logic rst_i,
   // received link side
   input mcoi_link_pkg::link_word_t interlock_word_i,
   input mcoi_link_pkg::motor_frame_t rx_frame_i,
   // driver status lines, active low
   input logic [NUM_MOTORS-1:0] motor_pfail_n_i,
   input logic [NUM_MOTORS-1:0] motor_sw_a_n_i,
   input logic [NUM_MOTORS-1:0] motor_sw_b_n_i,
   // AXI4-Lite read port
   input logic ar_valid_i,
   input mcoi_link_pkg::axi_addr_t ar_addr_i,
   input logic r_ready_i,
   // driver pins
   output logic [NUM_MOTORS-1:0] motor_step_o,
   output logic [NUM_MOTORS-1:0] motor_en_o,
   output logic [NUM_MOTORS-1:0] motor_dir_o,
   output logic [NUM_MOTORS-1:0] motor_boost_o,
   // transmitted link side
   output mcoi_link_pkg::motor_frame_t tx_frame_o,
   output logic ar_ready_o,
   output logic r_valid_o,
   output mcoi_link_pkg::axi_data_t r_data_o,
   output mcoi_link_pkg::axi_resp_t r_resp_o
);

   import mcoi_motor_pkg::*;

   motor_ctrl_t [NUM_MOTORS-1:0] motor_ctrl;
   motor_stat_t [NUM_MOTORS-1:0] motor_stat;
   logic link_locked;

   // ------------------------------------------------------------------------
   // control path
   // ------------------------------------------------------------------------

   link_interlock #(
      .NUM_MOTORS (NUM_MOTORS)
   ) i_link_interlock (
      .gbt_rx_clkrs (gbt_rx_clkrs),
      .rst_i (rst_i),
      .interlock_word_i (interlock_word_i),
      .rx_frame_i (rx_frame_i),
      .motor_ctrl_o (motor_ctrl),
      .link_locked_o (link_locked)
   );

   // one channel per driver, motor_en_o carries the deactivate level
   for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_motor
      motor_channel i_motor_channel (
         .gbt_rx_clkrs (gbt_rx_clkrs),
         .rst_i (rst_i),
         .ctrl_i (motor_ctrl[m]),
         .pfail_n_i (motor_pfail_n_i[m]),
         .sw_a_n_i (motor_sw_a_n_i[m]),
         .sw_b_n_i (motor_sw_b_n_i[m]),
         .step_o (motor_step_o[m]),
         .deact_o (motor_en_o[m]),
         .dir_o (motor_dir_o[m]),
         .boost_o (motor_boost_o[m]),
         .status_o (motor_stat[m])
      );
   end

   // ------------------------------------------------------------------------
   // status path
   // ------------------------------------------------------------------------

   status_readback #(
      .NUM_MOTORS (NUM_MOTORS)
   ) i_status_readback (
      .gbt_rx_clkrs (gbt_rx_clkrs),
      .rst_i (rst_i),
      .motor_stat_i (motor_stat),
      .link_locked_i (link_locked),
      .ar_valid_i (ar_valid_i),
      .ar_addr_i (ar_addr_i),
      .r_ready_i (r_ready_i),
      .tx_frame_o (tx_frame_o),
      .ar_ready_o (ar_ready_o),
      .r_valid_o (r_valid_o),
      .r_data_o (r_data_o),
      .r_resp_o (r_resp_o)
   );

endmodule

/* verilog/status_readback.sv */
// packs synchronised motor statuses into the returned frame and serves them on an AXI4-Lite read port
module status_readback #(
   parameter int NUM_MOTORS = 16
) (
   input logic gbt_rx_clkrs,
   input logic rst_i,
   input mcoi_motor_pkg::motor_stat_t [NUM_MOTORS-1:0] motor_stat_i,
   input logic link_locked_i,
   input logic ar_valid_i,
   input mcoi_link_pkg::axi_addr_t ar_addr_i,
   input logic r_ready_i,
   output mcoi_link_pkg::motor_frame_t tx_frame_o,
   output logic ar_ready_o,
   output logic r_valid_o,
   output mcoi_link_pkg::axi_data_t r_data_o,
   output mcoi_link_pkg::axi_resp_t r_resp_o
);

   import mcoi_motor_pkg::*;
   import mcoi_link_pkg::*;

   // frame bits occupied by the populated motors
   localparam int STAT_BITS = NUM_MOTORS * $bits(motor_stat_t);

   typedef enum logic {
      rd_idle,
      rd_resp
   } rd_state_t;

   rd_state_t rd_state;
   motor_frame_t frame_next;
   logic rd_accept;
   axi_data_t rd_data_d;
   axi_resp_t rd_resp_d;

   // ------------------------------------------------------------------------
   // returned link frame
   // ------------------------------------------------------------------------

   // motor m in nibble m, nibbles of absent motors stay zero
   always_comb begin
      frame_next = '0;
      frame_next[STAT_BITS-1:0] = motor_stat_i;
   end

   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         tx_frame_o <= '0;
      end else begin
         tx_frame_o <= frame_next;
      end
   end

   // ------------------------------------------------------------------------
   // read address decode
   // ------------------------------------------------------------------------

   // anything not matched below falls through to the error word
   // misaligned motor addresses never match a base plus 4*m slot
   always_comb begin
      rd_data_d = BAD_ADDR_WORD;
      rd_resp_d = RESP_SLVERR;
      if (ar_addr_i == REG_LINK_STATUS) begin
         rd_data_d = axi_data_t'(link_locked_i);
         rd_resp_d = RESP_OKAY;
      end
      for (int m = 0; m < NUM_MOTORS; m++) begin
         if (ar_addr_i == axi_addr_t'(REG_MOTOR_BASE + 4 * m)) begin
            // status zero-extended into the data word
            rd_data_d = axi_data_t'(motor_stat_i[m]);
            rd_resp_d = RESP_OKAY;
         end
      end
   end

   // ------------------------------------------------------------------------
   // read handshake FSM
   // ------------------------------------------------------------------------

   // one read in flight, the address channel closes while a response waits
   assign ar_ready_o = (rd_state == rd_idle);
   assign r_valid_o = (rd_state == rd_resp);
   assign rd_accept = ar_valid_i && ar_ready_o;

   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         rd_state <= rd_idle;
      end else begin
         case (rd_state)
            rd_idle: begin
               if (ar_valid_i) begin
                  rd_state <= rd_resp;
               end
            end
            rd_resp: begin
               // master took the data
               if (r_ready_i) begin
                  rd_state <= rd_idle;
               end
            end
         endcase
      end
   end

   // data snapshot taken at address acceptance, held through back-pressure
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rd_accept) begin
         r_data_o <= rd_data_d;
         r_resp_o <= rd_resp_d;
      end
   end

   // ------------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------------

   // a stalled response keeps its valid, data and code
   a_resp_hold : assert property (
      @(posedge gbt_rx_clkrs) disable iff (rst_i)
      (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
   ) else $error("read response changed while stalled");

endmodule

/* verilog/motor_channel.sv */
// one stepper driver: control nibble onto the driver pins, status lines synchronised back
module motor_channel (
   input logic gbt_rx_clkrs,
   input logic rst_i,
   input mcoi_motor_pkg::motor_ctrl_t ctrl_i,
   input logic pfail_n_i,
   input logic sw_a_n_i,
   input logic sw_b_n_i,
   output logic step_o,
   output logic deact_o,
   output logic dir_o,
   output logic boost_o,
   output mcoi_motor_pkg::motor_stat_t status_o
);

   import mcoi_motor_pkg::*;

   motor_stat_t raw_stat;
   // stage 0 takes the raw lines, the last stage is the safe one
   motor_stat_t [SYNC_STAGES-1:0] sync_q;

   // ------------------------------------------------------------------------
   // driver pins
   // ------------------------------------------------------------------------

   // control is already registered upstream, pins follow it directly
   assign step_o = ctrl_i[CTRL_STEP_BIT];
   assign deact_o = ctrl_i[CTRL_DEACT_BIT];
   assign dir_o = ctrl_i[CTRL_DIR_BIT];
   assign boost_o = ctrl_i[CTRL_BOOST_BIT];

   // ------------------------------------------------------------------------
   // status lines
   // ------------------------------------------------------------------------

   // driver lines are active low, flip them to active high
   always_comb begin
      raw_stat = '0;
      raw_stat[STAT_FAIL_BIT] = ~pfail_n_i;
      raw_stat[STAT_SWA_BIT] = ~sw_a_n_i;
      raw_stat[STAT_SWB_BIT] = ~sw_b_n_i;
      // overheat is not wired on this driver
      raw_stat[STAT_OH_BIT] = 1'b0;
   end

   // lines are asynchronous to the link clock
   // shift them through the synchroniser chain
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], raw_stat};
      end
   end

   assign status_o = sync_q[SYNC_STAGES-1];

   // ------------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------------

   // reserved bit must stay clear all the way through the chain
   a_no_overheat : assert property (
      @(posedge gbt_rx_clkrs) disable iff (rst_i)
      !status_o[STAT_OH_BIT]
   ) else $error("overheat status set on a channel without overheat sense");

endmodule

/* verilog/link_interlock.sv */
// registers the received motor controls, passed only while the link interlock word matches
module link_interlock #(
   parameter int NUM_MOTORS = 16
) (
   input logic gbt_rx_clkrs,
   input logic rst_i,
   input mcoi_link_pkg::link_word_t interlock_word_i,
   input mcoi_link_pkg::motor_frame_t rx_frame_i,
   output mcoi_motor_pkg::motor_ctrl_t [NUM_MOTORS-1:0] motor_ctrl_o,
   output logic link_locked_o
);

   import mcoi_motor_pkg::*;
   import mcoi_link_pkg::*;

   // number of frame bits that belong to the populated motors
   localparam int CTRL_BITS = NUM_MOTORS * $bits(motor_ctrl_t);

   logic key_match;
   logic all_deact;

   // far end closes the loop by echoing the key
   assign key_match = (interlock_word_i == INTERLOCK_KEY);

   // ------------------------------------------------------------------------
   // control capture
   // ------------------------------------------------------------------------

   // all ones sets every deactivate bit, so the drivers stay off while
   // the link is down, not yet established or in reset
   always_ff @(posedge gbt_rx_clkrs) begin
      if (rst_i) begin
         link_locked_o <= 1'b0;
         motor_ctrl_o <= '1;
      end else begin
         link_locked_o <= key_match;
         if (key_match) begin
            // nibble m of the frame goes to motor m
            motor_ctrl_o <= rx_frame_i[CTRL_BITS-1:0];
         end else begin
            motor_ctrl_o <= '1;
         end
      end
   end

   // ------------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------------

   // collect the deactivate bits of all motors
   always_comb begin
      all_deact = 1'b1;
      for (int m = 0; m < NUM_MOTORS; m++) begin
         all_deact = all_deact & motor_ctrl_o[m][CTRL_DEACT_BIT];
      end
   end

   // link not locked means no driver may be active
   a_unlocked_deact : assert property (
      @(posedge gbt_rx_clkrs) disable iff (rst_i)
      !link_locked_o |-> all_deact
   ) else $error("motor enabled while the interlock is open");

endmodule

/* verilog/mcoi_link_pkg.sv */
// link frame widths, interlock key and AXI4-Lite readback map shared by the motor path
package mcoi_link_pkg;

   // ------------------------------------------------------------------------
   // link frame
   // ------------------------------------------------------------------------

   // interlock word echoed back by the far end of the fibre
   typedef logic [31:0] link_word_t;

   // motor part of the frame, 4 bits per motor, 16 motors at most
   localparam int FRAME_W = 64;
   typedef logic [FRAME_W-1:0] motor_frame_t;

   // control bits reach the drivers only while the interlock word
   // carries this value
   localparam link_word_t INTERLOCK_KEY = 32'ha5c3_3c5a;

   // ------------------------------------------------------------------------
   // AXI4-Lite read port
   // ------------------------------------------------------------------------

   typedef logic [7:0] axi_addr_t;
   typedef logic [31:0] axi_data_t;
   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t RESP_OKAY = 2'b00;
   localparam axi_resp_t RESP_SLVERR = 2'b10;

   // bit 0 holds the registered interlock match
   localparam axi_addr_t REG_LINK_STATUS = 8'h00;
   // motor m status at base plus 4*m, word aligned
   localparam axi_addr_t REG_MOTOR_BASE = 8'h40;

   // data word returned with SLVERR for anything outside the map
   localparam axi_data_t BAD_ADDR_WORD = 32'hdeadbeef;

endpackage

/* verilog/mcoi_motor_pkg.sv */
// per-motor control and status field types, imported by every RTL block of the motor path
package mcoi_motor_pkg;

   // ------------------------------------------------------------------------
   // control nibble, one per motor, as carried in the received link frame
   // ------------------------------------------------------------------------

   // bit 0 step, bit 1 deactivate, bit 2 direction, bit 3 boost
   typedef logic [3:0] motor_ctrl_t;

   // step pulse towards the driver clock input
   localparam int CTRL_STEP_BIT = 0;
   // driver deactivate, high keeps the motor unpowered
   localparam int CTRL_DEACT_BIT = 1;
   // rotation direction
   localparam int CTRL_DIR_BIT = 2;
   // current boost
   localparam int CTRL_BOOST_BIT = 3;

   // ------------------------------------------------------------------------
   // status nibble, one per motor, as returned in the transmitted frame
   // ------------------------------------------------------------------------

   // all bits active high once inverted from the driver lines
   typedef logic [3:0] motor_stat_t;

   // driver power fail
   localparam int STAT_FAIL_BIT = 0;
   // extremity switch A
   localparam int STAT_SWA_BIT = 1;
   // extremity switch B
   localparam int STAT_SWB_BIT = 2;
   // overheat, reserved, the driver does not report it
   localparam int STAT_OH_BIT = 3;

   // depth of the flop chain that brings the asynchronous driver
   // lines into the link clock domain
   localparam int SYNC_STAGES = 3;

endpackage
